/* compile.f */
+incdir+src
src/mma_pkg.sv
src/mma_operand_issue.sv
src/mma_operand_fifo.sv
src/mma_array.sv
src/mma_top.sv
tb/mma_chk.sv
tb/mma_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MMA engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mma_tb \
    -Mdir obj_dir \
    -f compile.f

./obj_dir/Vmma_tb > sim.log 2>&1 || true
cat sim.log

# Both lines are searched so that a run cut short also counts as failed
if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi

echo "Run passed"

/* src/mma_array.sv */
// Two-stage pipelined MAC array computing D = A * B + C.
// Stage 1 registers the K element products of every output element and C,
// stage 2 registers their tree sum plus C and presents it with valid_out.
// Each pop from the operand FIFO hands one credit back to the issue stage.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_array (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic                         fifo_valid,
    input  mma_pkg::mma_elem_u           rd_a [`MMA_M][`MMA_K],
    input  mma_pkg::mma_elem_u           rd_b [`MMA_K][`MMA_N],
    input  logic signed [`MMA_ACC_W-1:0] rd_c [`MMA_M][`MMA_N],
    input  logic                         rd_half,
    input  logic                         ready_out,
    output logic                         fifo_rd,
    output logic                         credit_return,
    output logic                         valid_out,
    output logic signed [`MMA_ACC_W-1:0] d [`MMA_M][`MMA_N]
);
    import mma_pkg::*;

    localparam int prod_w = 2 * `MMA_P;
    localparam int acc_w  = `MMA_ACC_W;

    logic signed [prod_w-1:0] prod    [`MMA_M][`MMA_N][`MMA_K];
    logic signed [prod_w-1:0] s1_prod [`MMA_M][`MMA_N][`MMA_K];
    logic signed [acc_w-1:0]  s1_c    [`MMA_M][`MMA_N];
    logic                     s1_valid;
    logic                     advance;

    // One element product in either precision
    function automatic logic signed [prod_w-1:0] elem_mul(
        input mma_elem_u x,
        input mma_elem_u y,
        input logic      half
    );
        logic signed [prod_w-1:0] p_hi;
        logic signed [prod_w-1:0] p_lo;
        logic signed [prod_w-1:0] p_full;
        p_hi   = prod_w'(x.lanes.hi) * prod_w'(y.lanes.hi);
        p_lo   = prod_w'(x.lanes.lo) * prod_w'(y.lanes.lo);
        p_full = prod_w'(x.full) * prod_w'(y.full);
        return half ? (p_hi + p_lo) : p_full;
    endfunction

    // Pairwise reduction, log2(K) levels deep
    function automatic logic signed [acc_w-1:0] tree_sum(
        input logic signed [prod_w-1:0] p [`MMA_K]
    );
        logic signed [acc_w-1:0] lvl [`MMA_K];
        for (int i = 0; i < `MMA_K; i++) begin
            lvl[i] = acc_w'(p[i]);
        end
        for (int s = 1; s < `MMA_K; s = s * 2) begin
            for (int i = 0; i + s < `MMA_K; i = i + 2 * s) begin
                lvl[i] = lvl[i] + lvl[i + s];
            end
        end
        return lvl[0];
    endfunction

    always_comb begin
        for (int m = 0; m < `MMA_M; m++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                for (int k = 0; k < `MMA_K; k++) begin
                    prod[m][n][k] = elem_mul(rd_a[m][k], rd_b[k][n], rd_half);
                end
            end
        end
    end

    // Whole pipeline moves when the output slot is free or being taken
    assign advance       = !valid_out || ready_out;
    assign fifo_rd       = fifo_valid && advance;
    assign credit_return = fifo_rd;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            valid_out <= 1'b0;
        end else if (advance) begin
            s1_valid  <= fifo_valid;
            valid_out <= s1_valid;
        end
    end

    // Stage 1 operands and stage 2 result
    always_ff @(posedge clk_i) begin
        if (advance) begin
            s1_prod <= prod;
            s1_c    <= rd_c;
            for (int m = 0; m < `MMA_M; m++) begin
                for (int n = 0; n < `MMA_N; n++) begin
                    d[m][n] <= tree_sum(s1_prod[m][n]) + s1_c[m][n];
                end
            end
        end
    end

endmodule

/* src/mma_cfg.svh */
// Build-time configuration of the matrix multiply-accumulate engine.
// Include this wherever matrix sizes, widths or the FIFO depth are needed.
// The defaults give a 2x2x2 array with 8-bit operands and 32-bit accumulators.
`ifndef MMA_CFG_SVH
`define MMA_CFG_SVH

// A is M by K, B is K by N, C and D are M by N
`define MMA_M 2
`define MMA_N 2
`define MMA_K 2

// Operand element width, must be even for the two half-precision lanes
`define MMA_P 8
`define MMA_ACC_W 32

// Operand FIFO entries, also the number of credits at reset
`define MMA_FIFO_DEPTH 4
`define MMA_CREDIT_W ($clog2(`MMA_FIFO_DEPTH + 1))

`endif

/* src/mma_operand_fifo.sv */
// Operand FIFO between the issue stage and the MAC array.
// Stores whole operand sets together with their precision flag and shows
// the head entry first-word fall-through. The issue stage's credits bound
// the occupancy, so there is no full flag and no overflow guard here.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_operand_fifo (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic                         fifo_wr,
    input  mma_pkg::mma_elem_u           wr_a [`MMA_M][`MMA_K],
    input  mma_pkg::mma_elem_u           wr_b [`MMA_K][`MMA_N],
    input  logic signed [`MMA_ACC_W-1:0] wr_c [`MMA_M][`MMA_N],
    input  logic                         wr_half,
    input  logic                         fifo_rd,
    output logic                         fifo_valid,
    output mma_pkg::mma_elem_u           rd_a [`MMA_M][`MMA_K],
    output mma_pkg::mma_elem_u           rd_b [`MMA_K][`MMA_N],
    output logic signed [`MMA_ACC_W-1:0] rd_c [`MMA_M][`MMA_N],
    output logic                         rd_half
);
    import mma_pkg::*;

    localparam int depth = `MMA_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    mma_elem_u                   mem_a    [depth][`MMA_M][`MMA_K];
    mma_elem_u                   mem_b    [depth][`MMA_K][`MMA_N];
    logic signed [`MMA_ACC_W-1:0] mem_c   [depth][`MMA_M][`MMA_N];
    logic                        mem_half [depth];

    logic [ptr_w-1:0]         wr_ptr;
    logic [ptr_w-1:0]         rd_ptr;
    logic [`MMA_CREDIT_W-1:0] count;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge clk_i) begin
        if (fifo_wr) begin
            mem_a[wr_ptr]    <= wr_a;
            mem_b[wr_ptr]    <= wr_b;
            mem_c[wr_ptr]    <= wr_c;
            mem_half[wr_ptr] <= wr_half;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (fifo_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (fifo_wr && !fifo_rd) begin
                count <= count + 1'b1;
            end else if (!fifo_wr && fifo_rd) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry shown without a read request
    assign fifo_valid = (count != '0);
    assign rd_a       = mem_a[rd_ptr];
    assign rd_b       = mem_b[rd_ptr];
    assign rd_c       = mem_c[rd_ptr];
    assign rd_half    = mem_half[rd_ptr];

endmodule

/* src/mma_operand_issue.sv */
// Operand issue stage of the MMA engine.
// Accepts transactions with a valid/ready handshake and writes each one into
// the operand FIFO. A credit counter, refilled by the MAC array as it pops,
// keeps the FIFO from ever overflowing.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_operand_issue (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic                         valid_in,
    input  mma_pkg::mma_elem_u           a [`MMA_M][`MMA_K],
    input  mma_pkg::mma_elem_u           b [`MMA_K][`MMA_N],
    input  logic signed [`MMA_ACC_W-1:0] c [`MMA_M][`MMA_N],
    input  logic                         half_precision,
    input  logic                         credit_return,
    output logic                         ready_in,
    output logic                         fifo_wr,
    output mma_pkg::mma_elem_u           wr_a [`MMA_M][`MMA_K],
    output mma_pkg::mma_elem_u           wr_b [`MMA_K][`MMA_N],
    output logic signed [`MMA_ACC_W-1:0] wr_c [`MMA_M][`MMA_N],
    output logic                         wr_half
);

    localparam logic [`MMA_CREDIT_W-1:0] credit_init = (`MMA_CREDIT_W)'(`MMA_FIFO_DEPTH);

    logic [`MMA_CREDIT_W-1:0] credits;
    logic                     accept;

    // Free FIFO slots decide whether new work may enter
    assign ready_in = (credits != '0);
    assign accept   = valid_in && ready_in;

    // The accepted operand set goes straight into the FIFO
    assign fifo_wr = accept;
    assign wr_a    = a;
    assign wr_b    = b;
    assign wr_c    = c;
    assign wr_half = half_precision;

    // Spend on accept, refill on return, unchanged when both happen
    always_ff @(posedge clk_i) begin
        if (rst) begin
            credits <= credit_init;
        end else if (accept && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!accept && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

/* src/mma_pkg.sv */
// Shared types of the matrix multiply-accumulate engine.
// One operand element is read either as one signed integer or as two
// signed half-width lanes, so it is carried as a packed union.
`include "mma_cfg.svh"

package mma_pkg;

    // Two signed lanes used in half precision
    typedef struct packed {
        logic signed [`MMA_P/2-1:0] hi;
        logic signed [`MMA_P/2-1:0] lo;
    } mma_lanes_t;

    // Full view for full precision, lane view for half precision
    typedef union packed {
        logic signed [`MMA_P-1:0] full;
        mma_lanes_t               lanes;
    } mma_elem_u;

endpackage

/* src/mma_top.sv */
// Top level of the streaming matrix multiply-accumulate engine.
// Operands enter through a valid/ready handshake into the issue stage, wait
// in the operand FIFO and leave the MAC array as D = A * B + C, again under
// valid/ready. Credits flow back from the array to the issue stage.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_top (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic                         valid_in,
    output logic                         ready_in,
    input  mma_pkg::mma_elem_u           a [`MMA_M][`MMA_K],
    input  mma_pkg::mma_elem_u           b [`MMA_K][`MMA_N],
    input  logic signed [`MMA_ACC_W-1:0] c [`MMA_M][`MMA_N],
    input  logic                         half_precision,
    output logic                         valid_out,
    input  logic                         ready_out,
    output logic signed [`MMA_ACC_W-1:0] d [`MMA_M][`MMA_N]
);
    import mma_pkg::*;

    // Issue stage to FIFO
    logic                         fifo_wr;
    mma_elem_u                    wr_a [`MMA_M][`MMA_K];
    mma_elem_u                    wr_b [`MMA_K][`MMA_N];
    logic signed [`MMA_ACC_W-1:0] wr_c [`MMA_M][`MMA_N];
    logic                         wr_half;

    // FIFO to MAC array
    logic                         fifo_valid;
    logic                         fifo_rd;
    mma_elem_u                    rd_a [`MMA_M][`MMA_K];
    mma_elem_u                    rd_b [`MMA_K][`MMA_N];
    logic signed [`MMA_ACC_W-1:0] rd_c [`MMA_M][`MMA_N];
    logic                         rd_half;

    logic                         credit_return;

    mma_operand_issue u_issue (
        .clk_i          (clk_i),
        .rst            (rst),
        .valid_in       (valid_in),
        .a              (a),
        .b              (b),
        .c              (c),
        .half_precision (half_precision),
        .credit_return  (credit_return),
        .ready_in       (ready_in),
        .fifo_wr        (fifo_wr),
        .wr_a           (wr_a),
        .wr_b           (wr_b),
        .wr_c           (wr_c),
        .wr_half        (wr_half)
    );

    mma_operand_fifo u_fifo (
        .clk_i      (clk_i),
        .rst        (rst),
        .fifo_wr    (fifo_wr),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .wr_c       (wr_c),
        .wr_half    (wr_half),
        .fifo_rd    (fifo_rd),
        .fifo_valid (fifo_valid),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .rd_c       (rd_c),
        .rd_half    (rd_half)
    );

    mma_array u_array (
        .clk_i         (clk_i),
        .rst           (rst),
        .fifo_valid    (fifo_valid),
        .rd_a          (rd_a),
        .rd_b          (rd_b),
        .rd_c          (rd_c),
        .rd_half       (rd_half),
        .ready_out     (ready_out),
        .fifo_rd       (fifo_rd),
        .credit_return (credit_return),
        .valid_out     (valid_out),
        .d             (d)
    );

endmodule

/* tb/mma_chk.sv */
// Protocol checker for the MMA engine, bound into the top level.
// Watches the credit counter, the FIFO occupancy and the output handshake.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_chk (
    input logic                         clk_i,
    input logic                         rst,
    input logic                         fifo_wr,
    input logic [`MMA_CREDIT_W-1:0]     fifo_count,
    input logic [`MMA_CREDIT_W-1:0]     credits,
    input logic                         valid_out,
    input logic                         ready_out,
    input logic signed [`MMA_ACC_W-1:0] d [`MMA_M][`MMA_N]
);

    localparam logic [`MMA_CREDIT_W-1:0] depth = (`MMA_CREDIT_W)'(`MMA_FIFO_DEPTH);

    logic [`MMA_M*`MMA_N*`MMA_ACC_W-1:0] d_flat;

    always_comb begin
        for (int m = 0; m < `MMA_M; m++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                d_flat[(m * `MMA_N + n) * `MMA_ACC_W +: `MMA_ACC_W] = d[m][n];
            end
        end
    end

    // A full FIFO means the issue stage has no credit left
    no_overflow: assert property (@(posedge clk_i) disable iff (rst)
        fifo_wr |-> fifo_count < depth)
        else $error("operand FIFO written while full");

    credit_bound: assert property (@(posedge clk_i) disable iff (rst)
        credits <= depth)
        else $error("credit count above FIFO depth");

    // Stalled result must hold
    valid_hold: assert property (@(posedge clk_i) disable iff (rst)
        valid_out && !ready_out |=> valid_out)
        else $error("valid_out dropped while stalled");

    data_hold: assert property (@(posedge clk_i) disable iff (rst)
        valid_out && !ready_out |=> $stable(d_flat))
        else $error("d changed while stalled");

endmodule

bind mma_top mma_chk u_chk (
    .clk_i      (clk_i),
    .rst        (rst),
    .fifo_wr    (fifo_wr),
    .fifo_count (u_fifo.count),
    .credits    (u_issue.credits),
    .valid_out  (valid_out),
    .ready_out  (ready_out),
    .d          (d)
);

/* tb/mma_tb.sv */
// Testbench for the streaming MMA engine.
// Applies a table of eight operand sets, first with the output stalled to
// probe the credit limit, then under random output back-pressure, and checks
// every result in order against a reference model of D = A * B + C.
`timescale 1ns/1ns
`include "mma_cfg.svh"

module mma_tb;
    import mma_pkg::*;

    localparam int n_tests        = 8;
    localparam int a_bits         = `MMA_M * `MMA_K * `MMA_P;
    localparam int b_bits         = `MMA_K * `MMA_N * `MMA_P;
    localparam int c_bits         = `MMA_M * `MMA_N * `MMA_ACC_W;
    localparam int timeout_cycles = n_tests * (`MMA_FIFO_DEPTH + 3) * 4;

    // Element (row, col) sits at bits (row * cols + col) * width of each word
    logic [a_bits-1:0] tbl_a [n_tests] = '{
        32'h807f_7f80, 32'h05fd_11c8, 32'h8887_787f, 32'h8ff8_12e7,
        32'h8080_8080, 32'h7f80_ff01, 32'h8ff8_8877, 32'h3cc4_9a66
    };
    logic [b_bits-1:0] tbl_b [n_tests] = '{
        32'h80ff_7f01, 32'h7f7f_8080, 32'h8888_7f81, 32'h873c_d58a,
        32'h8080_8080, 32'h01ff_807f, 32'h7788_f88f, 32'h12ee_817e
    };
    // Entries 4 and 5 push C to both ends of the accumulator range
    logic [c_bits-1:0] tbl_c [n_tests] = '{
        128'h0,
        128'h0000_0064_ffff_ff9c_0000_0001_ffff_ffff,
        128'h0,
        128'h0000_0010_ffff_fff0_0000_0100_ffff_ff00,
        128'h8000_0001_ffff_8000_7fff_0000_8000_0000,
        128'h0012_3456_8000_7fff_ffff_fff0_7fff_0000,
        128'h7fff_ff00_8000_0000_0000_0100_ffff_ff00,
        128'h0000_0002_ffff_fffe_0bad_f00d_dead_beef
    };
    // Half precision on entries 2, 3 and 6
    logic [n_tests-1:0] tbl_half = 8'b0100_1100;

    logic                         clk_i = 1'b0;
    logic                         rst;
    logic                         valid_in;
    logic                         ready_in;
    mma_elem_u                    a [`MMA_M][`MMA_K];
    mma_elem_u                    b [`MMA_K][`MMA_N];
    logic signed [`MMA_ACC_W-1:0] c [`MMA_M][`MMA_N];
    logic                         half_precision;
    logic                         valid_out;
    logic                         ready_out = 1'b0;
    logic signed [`MMA_ACC_W-1:0] d [`MMA_M][`MMA_N];

    logic              hold_out   = 1'b1;
    logic [31:0]       lfsr_state = 32'h1dd1;
    logic [31:0]       lfsr_nxt;
    logic [c_bits-1:0] exp_q [$];
    logic [c_bits-1:0] exp_word;
    int                results = 0;
    int                cycles  = 0;

    mma_top DUT (
        .clk_i          (clk_i),
        .rst            (rst),
        .valid_in       (valid_in),
        .ready_in       (ready_in),
        .a              (a),
        .b              (b),
        .c              (c),
        .half_precision (half_precision),
        .valid_out      (valid_out),
        .ready_out      (ready_out),
        .d              (d)
    );

    always #2 clk_i = ~clk_i;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [c_bits-1:0] expected_d(input int i);
        logic [c_bits-1:0] r;
        logic [`MMA_P-1:0] x;
        logic [`MMA_P-1:0] y;
        longint            acc;
        r = '0;
        for (int m = 0; m < `MMA_M; m++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                acc = longint'($signed(tbl_c[i][(m * `MMA_N + n) * `MMA_ACC_W +: `MMA_ACC_W]));
                for (int k = 0; k < `MMA_K; k++) begin
                    x = tbl_a[i][(m * `MMA_K + k) * `MMA_P +: `MMA_P];
                    y = tbl_b[i][(k * `MMA_N + n) * `MMA_P +: `MMA_P];
                    if (tbl_half[i]) begin
                        acc += longint'($signed(x[`MMA_P-1:`MMA_P/2]))
                             * longint'($signed(y[`MMA_P-1:`MMA_P/2]));
                        acc += longint'($signed(x[`MMA_P/2-1:0]))
                             * longint'($signed(y[`MMA_P/2-1:0]));
                    end else begin
                        acc += longint'($signed(x)) * longint'($signed(y));
                    end
                end
                r[(m * `MMA_N + n) * `MMA_ACC_W +: `MMA_ACC_W] = acc[`MMA_ACC_W-1:0];
            end
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input longint expected,
                                 input longint actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called on a rising edge, returns on the edge that transfers entry i
    task automatic send_entry(input int i);
        valid_in       <= 1'b1;
        half_precision <= tbl_half[i];
        for (int m = 0; m < `MMA_M; m++) begin
            for (int k = 0; k < `MMA_K; k++) begin
                a[m][k] <= tbl_a[i][(m * `MMA_K + k) * `MMA_P +: `MMA_P];
            end
        end
        for (int k = 0; k < `MMA_K; k++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                b[k][n] <= tbl_b[i][(k * `MMA_N + n) * `MMA_P +: `MMA_P];
            end
        end
        for (int m = 0; m < `MMA_M; m++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                c[m][n] <= tbl_c[i][(m * `MMA_N + n) * `MMA_ACC_W +: `MMA_ACC_W];
            end
        end
        @(negedge clk_i);
        while (!ready_in) begin
            @(negedge clk_i);
        end
        exp_q.push_back(expected_d(i));
        @(posedge clk_i);
    endtask

    // Output back-pressure, one LFSR step per bit taken
    assign lfsr_nxt = lfsr_next(lfsr_state);

    always @(posedge clk_i) begin
        if (rst || hold_out) begin
            ready_out <= 1'b0;
        end else begin
            lfsr_state <= lfsr_nxt;
            ready_out  <= lfsr_nxt[0];
        end
    end

    // Handshake signals are settled at the falling edge
    always @(negedge clk_i) begin
        if (!rst && valid_out && ready_out) begin
            if (exp_q.size() == 0) begin
                $display("A result was delivered with no transaction outstanding");
                $display("Simulation FAILED");
                $fatal(1, "unexpected result");
            end else begin
                exp_word = exp_q.pop_front();
                for (int m = 0; m < `MMA_M; m++) begin
                    for (int n = 0; n < `MMA_N; n++) begin
                        compare_value($sformatf("entry %0d d[%0d][%0d]", results, m, n),
                            longint'($signed(exp_word[(m * `MMA_N + n) * `MMA_ACC_W +:
                                                      `MMA_ACC_W])),
                            longint'(d[m][n]));
                    end
                end
                results++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: not all results arrived within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst            = 1'b1;
        valid_in       = 1'b0;
        half_precision = 1'b0;
        for (int m = 0; m < `MMA_M; m++) begin
            for (int k = 0; k < `MMA_K; k++) begin
                a[m][k] = '0;
            end
        end
        for (int k = 0; k < `MMA_K; k++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                b[k][n] = '0;
            end
        end
        for (int m = 0; m < `MMA_M; m++) begin
            for (int n = 0; n < `MMA_N; n++) begin
                c[m][n] = '0;
            end
        end
        repeat (4) @(posedge clk_i);
        rst <= 1'b0;

        // Output stalled, so FIFO plus both pipeline stages fill up
        for (int i = 0; i < `MMA_FIFO_DEPTH + 2; i++) begin
            send_entry(i);
        end
        valid_in <= 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            compare_value("credit_limit ready_in", longint'(0), longint'(ready_in));
        end

        @(posedge clk_i);
        hold_out <= 1'b0;
        for (int i = `MMA_FIFO_DEPTH + 2; i < n_tests; i++) begin
            send_entry(i);
        end
        valid_in <= 1'b0;

        while (results < n_tests) begin
            @(posedge clk_i);
        end
        // A few more cycles so that a surplus result would still be caught
        repeat (4) @(posedge clk_i);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
